// ==== tb.f ====
common/cache_cfg_pkg.sv
common/cache_ctrl_pkg.sv
hw/write_buffer.sv
hw/back_end.sv
hw/cache_control.sv
cache_memory/cache_memory.sv
front_end/front_end.sv
hw/cache_top.sv
verif/tb_mem_model.sv
verif/tb_cache.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f tb.f --top-module tb_cache -o tb_cache_sim

./obj_dir/tb_cache_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
   echo "Run result: pass"
else
   echo "Run result: fail"
   exit 1
fi

// ==== verif/tb_cache.sv ====
`timescale 1ns/1ps

module tb_cache;
   import cache_ctrl_pkg::*;

   localparam int TIMEOUT = 200;    // Cycles allowed per request

   logic        clk;
   logic        reset;
   logic        valid;
   logic [16:0] addr;               // Bit 16 picks the controller
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        ready;
   logic [31:0] rdata;
   logic        mem_valid;
   logic [13:0] mem_addr;
   logic [31:0] mem_wdata;
   logic [3:0]  mem_wstrb;
   logic        mem_ready;
   logic [31:0] mem_rdata;

   // Reference model
   logic [31:0] shadow_mem [16384];
   logic [15:0] sh_valid;
   logic [7:0]  sh_tag [16];
   int          n_ev [4];           // Read hit, read miss, write hit, write miss

   // Check state
   logic        chk_en;
   logic [16:0] chk_addr;
   logic [31:0] exp_rdata;
   logic [31:0] last_rdata;
   logic        abort;              // Set on a timeout to skip the rest
   int          errors;
   int          checks;

   cache_top #(.ADDR_W(16), .DATA_W(32), .INDEX_W(4), .BUF_DEPTH(4)) dut0 (
      .clk, .reset, .valid, .addr, .wdata, .wstrb, .ready, .rdata,
      .mem_valid, .mem_addr, .mem_wdata, .mem_wstrb, .mem_ready, .mem_rdata
   );

   tb_mem_model #(.AW(14), .DATA_W(32)) mem0 (
      .clk, .reset, .mem_valid, .mem_addr, .mem_wdata, .mem_wstrb, .mem_ready, .mem_rdata
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   read_data_ok: assert property (@(posedge clk) disable iff (reset)
      (ready && chk_en && !chk_addr[16]) |-> (rdata == exp_rdata))
   else
   begin
      errors++;
      $display("FAILED rdata at address %h: got %h, expected %h",
               $sampled(chk_addr[15:0]), $sampled(rdata), $sampled(exp_rdata));
   end

   ctrl_data_ok: assert property (@(posedge clk) disable iff (reset)
      (ready && chk_en && chk_addr[16]) |-> (rdata == exp_rdata))
   else
   begin
      errors++;
      $display("FAILED rdata for controller task %h: got %h, expected %h",
               $sampled(chk_addr[3:0]), $sampled(rdata), $sampled(exp_rdata));
   end

   ready_one_cycle: assert property (@(posedge clk) disable iff (reset) ready |=> !ready)
   else
   begin
      errors++;
      $display("Ready stayed high for more than one cycle");
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic hit_in_shadow(input logic [15:0] a);
      return sh_valid[a[7:4]] && (sh_tag[a[7:4]] == a[15:8]);
   endfunction

   // Three tags over four lines, so lines get evicted
   function automatic logic [15:0] pick_addr();
      logic [7:0] tag;
      case ($urandom_range(2, 0))
         0:       tag = 8'h00;
         1:       tag = 8'h01;
         default: tag = 8'hc3;
      endcase
      return {tag, 4'($urandom_range(3, 0)), 2'($urandom_range(3, 0)), 2'b00};
   endfunction

   // Starts on a falling edge and returns on the falling edge after ready
   task automatic issue_request(input logic [16:0] a, input logic [31:0] d,
                                input logic [3:0] s);
      int n;
      n = 0;
      if (abort)
         return;
      chk_addr = a;
      valid    = 1'b1;
      addr     = a;
      wdata    = d;
      wstrb    = s;
      @(negedge clk);
      while (!ready && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (ready)
      begin
         last_rdata = rdata;
         if (chk_en)
            checks++;
      end
      else
      begin
         errors++;
         abort = 1'b1;
         $display("Request to address %h timed out: ready never came", a);
      end
      @(negedge clk);                            // Ready taken at the edge in between
      valid  = 1'b0;
      wstrb  = '0;
      chk_en = 1'b0;
   endtask

   task automatic read_word(input logic [15:0] a);
      if (hit_in_shadow(a))
         n_ev[0]++;
      else
      begin
         n_ev[1]++;
         sh_valid[a[7:4]] = 1'b1;                // Line fill
         sh_tag[a[7:4]]   = a[15:8];
      end
      exp_rdata = shadow_mem[a[15:2]];
      chk_en    = 1'b1;
      issue_request({1'b0, a}, '0, '0);
   endtask

   task automatic write_word(input logic [15:0] a, input logic [31:0] d, input logic [3:0] s);
      if (hit_in_shadow(a))
         n_ev[2]++;
      else
         n_ev[3]++;                              // No allocation on a write miss
      for (int b = 0; b < 4; b++)
      begin
         if (s[b])
            shadow_mem[a[15:2]][8*b +: 8] = d[8*b +: 8];
      end
      issue_request({1'b0, a}, d, s);
   endtask

   task automatic ctrl_op(input ctrl_task_e t, input logic [31:0] exp, input logic chk);
      exp_rdata = exp;
      chk_en    = chk;
      issue_request({1'b1, 12'h000, t}, '0, '0);
   endtask

   task automatic check_counters();
      for (int i = 0; i < 4; i++)
         ctrl_op(ctrl_task_e'(4'(i)), 32'(n_ev[i]), 1'b1);
   endtask

   // Poll STATUS until the buffer has gone out to memory
   task automatic wait_write_idle();
      int n;
      n          = 0;
      last_rdata = '0;
      while (!last_rdata[0] && n < 50 && !abort)
      begin
         ctrl_op(STATUS, 32'h0, 1'b0);
         n++;
      end
      if (!last_rdata[0] && !abort)
      begin
         errors++;
         abort = 1'b1;
         $display("Write buffer never drained, STATUS kept write_idle low");
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      logic [15:0] a;
      void'($urandom(32'hde5d));
      reset    = 1'b1;
      valid    = 1'b0;
      addr     = '0;
      wdata    = '0;
      wstrb    = '0;
      chk_en   = 1'b0;
      chk_addr = '0;
      abort    = 1'b0;
      errors   = 0;
      checks   = 0;
      sh_valid = '0;
      for (int w = 0; w < 16384; w++)
         shadow_mem[w] = 32'(w) ^ 32'h5a5a0000;
      for (int i = 0; i < 4; i++)
         n_ev[i] = 0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      read_word(16'h0010);                       // Untouched line misses
      read_word(16'h0014);                       // Same line hits
      check_counters();

      // Mixed traffic over a small pool
      for (int i = 0; i < 40; i++)
      begin
         a = pick_addr();
         if ($urandom_range(1, 0) == 1)
            write_word(a, $urandom(), 4'($urandom_range(15, 1)));
         else
            read_word(a);
      end

      // Burst deeper than the buffer with half hits and half misses
      read_word(16'h2250);
      for (int i = 0; i < 8; i++)
         write_word({8'h22, (i < 4) ? 4'h5 : 4'h6, 2'(i), 2'b00}, $urandom(), 4'hf);
      for (int i = 0; i < 8; i++)
         read_word({8'h22, (i < 4) ? 4'h5 : 4'h6, 2'(i), 2'b00});

      check_counters();
      ctrl_op(RESET_CNT, 32'h0, 1'b1);
      for (int i = 0; i < 4; i++)
         n_ev[i] = 0;
      check_counters();                          // All zero now

      // Cached line must miss again after invalidate
      read_word(16'h2254);
      ctrl_op(INVALIDATE, 32'h0, 1'b1);
      sh_valid = '0;
      read_word(16'h2254);
      ctrl_op(READ_MISS_CNT, 32'(n_ev[1]), 1'b1);

      write_word(16'h0134, $urandom(), 4'b0110);
      write_word(16'h3378, $urandom(), 4'b1001);
      ctrl_op(STATUS, 32'h0, 1'b1);              // Second write still queued
      wait_write_idle();
      ctrl_op(STATUS, 32'h1, 1'b1);              // Not full and idle
      check_counters();

      @(negedge clk);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== verif/tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model #(
   parameter int AW     = 14,      // Word address width
   parameter int DATA_W = 32
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  mem_valid,
   input  logic [AW-1:0]         mem_addr,
   input  logic [DATA_W-1:0]     mem_wdata,
   input  logic [DATA_W/8-1:0]   mem_wstrb,
   output logic                  mem_ready,
   output logic [DATA_W-1:0]     mem_rdata
);
   logic [DATA_W-1:0] mem [2**AW];
   logic              busy;        // Latency countdown running
   int                delay;       // Cycles left before the answer

   // Each word starts as its own address, scrambled
   initial
   begin
      for (int i = 0; i < 2**AW; i++)
         mem[i] = 32'(i) ^ 32'h5a5a0000;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Response with a random wait of 0 to 3 cycles
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clk or posedge reset)
   begin
      int d;
      if (reset)
      begin
         mem_ready <= 1'b0;
         mem_rdata <= '0;
         busy      <= 1'b0;
         delay     <= 0;
      end
      else
      begin
         mem_ready <= 1'b0;                                   // One-cycle pulse
         if (mem_valid && !mem_ready)
         begin
            d = busy ? delay : int'($urandom_range(3, 0));   // New request draws a wait
            if (d == 0)
            begin
               mem_ready <= 1'b1;
               busy      <= 1'b0;
               mem_rdata <= mem[mem_addr];                    // Valid in the ready cycle
               for (int b = 0; b < DATA_W/8; b++)
               begin
                  if (mem_wstrb[b])
                     mem[mem_addr][8*b +: 8] <= mem_wdata[8*b +: 8];
               end
            end
            else
            begin
               busy  <= 1'b1;
               delay <= d - 1;
            end
         end
      end
   end

endmodule

// ==== hw/cache_top.sv ====
`timescale 1ns/1ps

module cache_top #(
   parameter int ADDR_W    = cache_cfg_pkg::ADDR_W,
   parameter int DATA_W    = cache_cfg_pkg::DATA_W,
   parameter int INDEX_W   = cache_cfg_pkg::INDEX_W,
   parameter int BUF_DEPTH = 4
) (
   input  logic                                 clk,
   input  logic                                 reset,
   // Processor port
   input  logic                                 valid,
   input  logic [ADDR_W:0]                      addr,      // MSB selects the controller
   input  logic [DATA_W-1:0]                    wdata,
   input  logic [DATA_W/8-1:0]                  wstrb,
   output logic                                 ready,
   output logic [DATA_W-1:0]                    rdata,
   // Main memory port, word addressed
   output logic                                 mem_valid,
   output logic [ADDR_W-$clog2(DATA_W/8)-1:0]   mem_addr,
   output logic [DATA_W-1:0]                    mem_wdata,
   output logic [DATA_W/8-1:0]                  mem_wstrb,
   input  logic                                 mem_ready,
   input  logic [DATA_W-1:0]                    mem_rdata
);
   import cache_cfg_pkg::*;
   import cache_ctrl_pkg::*;

   req_addr_u                 addr_r;        // Registered request address
   logic [DATA_W-1:0]         wdata_r;
   logic [DATA_W/8-1:0]       wstrb_r;
   logic                      hit;
   logic [DATA_W-1:0]         rdata_int;
   logic                      write_hit_en;
   logic                      read_miss;
   // Write buffer
   logic                      buf_push;
   logic                      buf_pop;
   logic                      buf_full;
   logic                      buf_empty;
   logic [ADDR_W-1:0]         buf_head_addr;
   logic [DATA_W-1:0]         buf_head_data;
   logic [DATA_W/8-1:0]       buf_head_strb;
   // Line fill
   logic                      fill_we;
   logic [WORD_OFF_W-1:0]     fill_word_off;
   logic [DATA_W-1:0]         fill_data;
   logic                      fill_done;
   logic                      write_idle;
   // Controller
   logic                      ctrl_valid;
   ctrl_task_e                ctrl_task;
   logic                      ctrl_ready;
   logic [DATA_W-1:0]         ctrl_data;
   access_ev_e                ev;
   logic                      ev_valid;
   logic                      invalidate;

   front_end #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) front_end0 (
      .clk, .reset, .valid, .addr, .wdata, .wstrb, .ready, .rdata,
      .addr_r, .wdata_r, .wstrb_r, .hit, .rdata_int, .write_hit_en,
      .buf_full, .buf_push, .read_miss, .fill_done,
      .ctrl_valid, .ctrl_task, .ctrl_ready, .ctrl_data, .ev, .ev_valid
   );

   cache_memory #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .INDEX_W(INDEX_W)) cache_memory0 (
      .clk, .reset,
      .index(addr_r.cache.index), .tag(addr_r.cache.tag), .word_off(addr_r.cache.word_off),
      .wdata(wdata_r), .wstrb(wstrb_r), .write_hit_en,
      .fill_we, .fill_word_off, .fill_data, .fill_done, .invalidate,
      .hit, .rdata_int
   );

   write_buffer #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .BUF_DEPTH(BUF_DEPTH)) write_buffer0 (
      .clk, .reset,
      .push(buf_push), .push_addr(addr_r), .push_data(wdata_r), .push_strb(wstrb_r),
      .pop(buf_pop), .full(buf_full), .empty(buf_empty),
      .head_addr(buf_head_addr), .head_data(buf_head_data), .head_strb(buf_head_strb)
   );

   back_end #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) back_end0 (
      .clk, .reset, .read_miss, .miss_addr(addr_r),
      .buf_empty, .buf_head_addr, .buf_head_data, .buf_head_strb,
      .mem_ready, .mem_rdata, .buf_pop,
      .fill_we, .fill_word_off, .fill_data, .fill_done, .write_idle,
      .mem_valid, .mem_addr, .mem_wdata, .mem_wstrb
   );

   cache_control #(.DATA_W(DATA_W)) cache_control0 (
      .clk, .reset, .ctrl_valid, .ctrl_task, .ev, .ev_valid,
      .buf_full, .write_idle, .ctrl_ready, .ctrl_data, .invalidate
   );

endmodule

// ==== front_end/front_end.sv ====
`timescale 1ns/1ps

module front_end #(
   parameter int ADDR_W = 16,
   parameter int DATA_W = 32
) (
   input  logic                         clk,
   input  logic                         reset,
   // Processor side
   input  logic                         valid,
   input  logic [ADDR_W:0]              addr,
   input  logic [DATA_W-1:0]            wdata,
   input  logic [DATA_W/8-1:0]          wstrb,
   output logic                         ready,
   output logic [DATA_W-1:0]            rdata,
   // Stored request
   output cache_cfg_pkg::req_addr_u     addr_r,
   output logic [DATA_W-1:0]            wdata_r,
   output logic [DATA_W/8-1:0]          wstrb_r,
   // Cache memory, write buffer and back end
   input  logic                         hit,
   input  logic [DATA_W-1:0]            rdata_int,
   output logic                         write_hit_en,
   input  logic                         buf_full,
   output logic                         buf_push,
   output logic                         read_miss,
   input  logic                         fill_done,
   // Controller
   output logic                         ctrl_valid,
   output cache_ctrl_pkg::ctrl_task_e   ctrl_task,
   input  logic                         ctrl_ready,
   input  logic [DATA_W-1:0]            ctrl_data,
   output cache_ctrl_pkg::access_ev_e   ev,
   output logic                         ev_valid
);
   import cache_cfg_pkg::*;
   import cache_ctrl_pkg::*;

   req_addr_u addr_in;       // Live address, read as a task
   logic      valid_r;       // A request is being served
   logic      ctrl_sel_r;    // Served request targets the controller
   logic      missed_r;      // This request already went through a fill
   logic      cache_req;
   logic      is_write;
   logic      rd_miss_now;
   logic      cache_ready;

   ////////////////////////////////////////////////////////////////////////////
   // Request capture
   ////////////////////////////////////////////////////////////////////////////

   // Capture only on a fresh request. In the ready cycle valid still shows
   // the request being answered, so ready alone clears valid_r
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         valid_r    <= 1'b0;
         ctrl_sel_r <= 1'b0;
      end
      else if (ready)
         valid_r <= 1'b0;
      else if (valid && !valid_r)
      begin
         valid_r    <= 1'b1;
         ctrl_sel_r <= addr[ADDR_W];
      end
   end

   always_ff @(posedge clk)
   begin
      if (valid && !valid_r)
      begin
         addr_r  <= addr[ADDR_W-1:0];
         wdata_r <= wdata;
         wstrb_r <= wstrb;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Path select
   ////////////////////////////////////////////////////////////////////////////

   assign addr_in    = addr[ADDR_W-1:0];
   assign ctrl_valid = valid & addr[ADDR_W];               // Not registered
   assign ctrl_task  = ctrl_task_e'(addr_in.ctrl.task_id);

   assign cache_req    = valid_r & ~ctrl_sel_r;
   assign is_write     = |wstrb_r;
   assign rd_miss_now  = cache_req & ~is_write & ~hit;
   assign buf_push     = cache_req & is_write & ~buf_full;   // Stalls on a full buffer
   assign write_hit_en = buf_push & hit;                     // Keep the line coherent
   assign cache_ready  = buf_push | (cache_req & ~is_write & hit);

   assign ready = ctrl_sel_r ? (valid_r & ctrl_ready) : cache_ready;
   assign rdata = ctrl_sel_r ? ctrl_data : rdata_int;

   // Miss request to the back end, held until the line is in
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         read_miss <= 1'b0;
         missed_r  <= 1'b0;
      end
      else
      begin
         if (fill_done)
            read_miss <= 1'b0;
         else if (rd_miss_now)
            read_miss <= 1'b1;
         missed_r <= (missed_r | rd_miss_now) & ~ready;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Access events
   ////////////////////////////////////////////////////////////////////////////

   assign ev_valid = cache_ready;

   always_comb
   begin
      if (!cache_ready)
         ev = NONE;
      else if (is_write)
         ev = hit ? WRITE_HIT : WRITE_MISS;
      else
         ev = missed_r ? READ_MISS : READ_HIT;    // Refilled read still counts as miss
   end

   // Exactly one ready per request
   a_ready_pulse: assert property (@(posedge clk) disable iff (reset)
      ready |-> valid_r ##1 !ready);

   a_push_room: assert property (@(posedge clk) disable iff (reset)
      buf_push |-> !buf_full);

endmodule

// ==== cache_memory/cache_memory.sv ====
`timescale 1ns/1ps

module cache_memory #(
   parameter  int ADDR_W  = 16,
   parameter  int DATA_W  = 32,
   parameter  int INDEX_W = 4,
   localparam int WO_W    = cache_cfg_pkg::WORD_OFF_W,
   localparam int TAG_W   = ADDR_W - INDEX_W - WO_W - $clog2(DATA_W/8)
) (
   input  logic                  clk,
   input  logic                  reset,
   // Request side
   input  logic [INDEX_W-1:0]    index,
   input  logic [TAG_W-1:0]      tag,
   input  logic [WO_W-1:0]       word_off,
   input  logic [DATA_W-1:0]     wdata,
   input  logic [DATA_W/8-1:0]   wstrb,
   input  logic                  write_hit_en,
   // Line fill from the back end
   input  logic                  fill_we,
   input  logic [WO_W-1:0]       fill_word_off,
   input  logic [DATA_W-1:0]     fill_data,
   input  logic                  fill_done,
   input  logic                  invalidate,
   output logic                  hit,
   output logic [DATA_W-1:0]     rdata_int
);
   import cache_cfg_pkg::*;

   localparam int LINES = 2**INDEX_W;

   logic [TAG_W-1:0]  tag_mem  [LINES];
   logic [LINES-1:0]  valid_bits;
   logic [DATA_W-1:0] data_mem [LINES*LINE_WORDS];   // Line-major word store

   ////////////////////////////////////////////////////////////////////////////
   // Lookup
   ////////////////////////////////////////////////////////////////////////////

   assign hit       = valid_bits[index] && (tag_mem[index] == tag);
   assign rdata_int = data_mem[{index, word_off}];

   // Valid bits
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         valid_bits <= '0;
      else if (invalidate)
         valid_bits <= '0;                 // Whole cache at once
      else if (fill_done)
         valid_bits[index] <= 1'b1;
   end

   // Tags and data
   always_ff @(posedge clk)
   begin
      if (fill_done)
         tag_mem[index] <= tag;            // Line now belongs to this tag
      if (fill_we)
         data_mem[{index, fill_word_off}] <= fill_data;
      if (write_hit_en)
      begin
         for (int b = 0; b < DATA_W/8; b++)
         begin
            if (wstrb[b])
               data_mem[{index, word_off}][8*b +: 8] <= wdata[8*b +: 8];
         end
      end
   end

   // Fills only happen for reads, write hits only for writes
   a_one_writer: assert property (@(posedge clk) disable iff (reset)
      !(fill_we && write_hit_en));

endmodule

// ==== hw/cache_control.sv ====
`timescale 1ns/1ps

module cache_control #(
   parameter int DATA_W = 32
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         ctrl_valid,
   input  cache_ctrl_pkg::ctrl_task_e   ctrl_task,
   input  cache_ctrl_pkg::access_ev_e   ev,
   input  logic                         ev_valid,
   input  logic                         buf_full,
   input  logic                         write_idle,
   output logic                         ctrl_ready,
   output logic [DATA_W-1:0]            ctrl_data,
   output logic                         invalidate
);
   import cache_ctrl_pkg::*;

   logic [CNT_W-1:0] cnt [4];    // Slot order follows the task codes
   logic             answer;
   logic             clear_cnt;
   logic [1:0]       ev_idx;

   assign answer     = ctrl_valid & ~ctrl_ready;   // Once per request
   assign invalidate = answer && (ctrl_task == INVALIDATE);
   assign clear_cnt  = answer && (ctrl_task == RESET_CNT);
   assign ev_idx     = 2'(ev - 3'd1);

   // Saturating event counters
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < 4; i++)
            cnt[i] <= '0;
      end
      else if (clear_cnt)
      begin
         for (int i = 0; i < 4; i++)
            cnt[i] <= '0;
      end
      else if (ev_valid && ev != NONE && cnt[ev_idx] != '1)
         cnt[ev_idx] <= cnt[ev_idx] + 1'b1;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         ctrl_ready <= 1'b0;
      else
         ctrl_ready <= answer;
   end

   // Answer word sampled with the request
   always_ff @(posedge clk)
   begin
      if (answer)
      begin
         case (ctrl_task)
            READ_HIT_CNT, READ_MISS_CNT, WRITE_HIT_CNT, WRITE_MISS_CNT:
               ctrl_data <= DATA_W'(cnt[ctrl_task[1:0]]);
            STATUS:
               ctrl_data <= DATA_W'({buf_full, write_idle});
            default:
               ctrl_data <= '0;
         endcase
      end
   end

endmodule

// ==== hw/back_end.sv ====
`timescale 1ns/1ps

module back_end #(
   parameter  int ADDR_W = 16,
   parameter  int DATA_W = 32,
   localparam int BO_W   = $clog2(DATA_W/8),
   localparam int WO_W   = cache_cfg_pkg::WORD_OFF_W
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     read_miss,
   input  logic [ADDR_W-1:0]        miss_addr,
   // Write buffer head
   input  logic                     buf_empty,
   input  logic [ADDR_W-1:0]        buf_head_addr,
   input  logic [DATA_W-1:0]        buf_head_data,
   input  logic [DATA_W/8-1:0]      buf_head_strb,
   input  logic                     mem_ready,
   input  logic [DATA_W-1:0]        mem_rdata,
   output logic                     buf_pop,
   // Line fill
   output logic                     fill_we,
   output logic [WO_W-1:0]          fill_word_off,
   output logic [DATA_W-1:0]        fill_data,
   output logic                     fill_done,
   output logic                     write_idle,
   // Main memory
   output logic                     mem_valid,
   output logic [ADDR_W-BO_W-1:0]   mem_addr,
   output logic [DATA_W-1:0]        mem_wdata,
   output logic [DATA_W/8-1:0]      mem_wstrb
);
   typedef enum logic [1:0] {IDLE, WRITE, READ, DONE} state_t;

   state_t          state;
   logic [WO_W-1:0] word_cnt;    // Word of the line being fetched

   // Buffered writes go out before any fill, so a miss sees them in memory
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state    <= IDLE;
         word_cnt <= '0;
      end
      else
      begin
         case (state)
            IDLE:
               if (!buf_empty)
                  state <= WRITE;
               else if (read_miss)
               begin
                  state    <= READ;
                  word_cnt <= '0;
               end
            WRITE:
               if (mem_ready)
                  state <= IDLE;       // Recheck the buffer
            READ:
               if (mem_ready)
               begin
                  word_cnt <= word_cnt + 1'b1;
                  if (word_cnt == '1)
                     state <= DONE;
               end
            default:
               state <= IDLE;          // DONE lasts one cycle
         endcase
      end
   end

   assign mem_valid = (state == WRITE) || (state == READ);
   assign mem_addr  = (state == WRITE) ? buf_head_addr[ADDR_W-1:BO_W]
                                       : {miss_addr[ADDR_W-1:BO_W+WO_W], word_cnt};
   assign mem_wdata = buf_head_data;
   assign mem_wstrb = (state == WRITE) ? buf_head_strb : '0;   // Zero strobe reads

   assign buf_pop       = (state == WRITE) && mem_ready;
   assign fill_we       = (state == READ) && mem_ready;
   assign fill_word_off = word_cnt;
   assign fill_data     = mem_rdata;
   assign fill_done     = (state == DONE);
   assign write_idle    = buf_empty && !mem_valid;

   a_addr_stable: assert property (@(posedge clk) disable iff (reset)
      mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr));

endmodule

// ==== hw/write_buffer.sv ====
`timescale 1ns/1ps

module write_buffer #(
   parameter int ADDR_W    = 16,
   parameter int DATA_W    = 32,
   parameter int BUF_DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  push,
   input  logic [ADDR_W-1:0]     push_addr,
   input  logic [DATA_W-1:0]     push_data,
   input  logic [DATA_W/8-1:0]   push_strb,
   input  logic                  pop,
   output logic                  full,
   output logic                  empty,
   output logic [ADDR_W-1:0]     head_addr,
   output logic [DATA_W-1:0]     head_data,
   output logic [DATA_W/8-1:0]   head_strb
);
   localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;

   logic [ADDR_W-1:0]   addr_q [BUF_DEPTH];
   logic [DATA_W-1:0]   data_q [BUF_DEPTH];
   logic [DATA_W/8-1:0] strb_q [BUF_DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [PTR_W:0]      count;     // Entries held

   // Wrap at the depth, which need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(BUF_DEPTH-1)) ? '0 : p + 1'b1;
   endfunction

   assign full      = (count == (PTR_W+1)'(BUF_DEPTH));
   assign empty     = (count == '0);
   assign head_addr = addr_q[rd_ptr];
   assign head_data = data_q[rd_ptr];
   assign head_strb = strb_q[rd_ptr];

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         addr_q[wr_ptr] <= push_addr;
         data_q[wr_ptr] <= push_data;
         strb_q[wr_ptr] <= push_strb;
      end
   end

   a_no_overflow: assert property (@(posedge clk) disable iff (reset) full |-> !push);
   a_no_underflow: assert property (@(posedge clk) disable iff (reset) empty |-> !pop);

endmodule

// ==== common/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

   // Controller tasks
   typedef enum logic [cache_cfg_pkg::TASK_W-1:0] {
      READ_HIT_CNT   = 4'd0,   // Counters first, so the low bits index them
      READ_MISS_CNT  = 4'd1,
      WRITE_HIT_CNT  = 4'd2,
      WRITE_MISS_CNT = 4'd3,
      STATUS         = 4'd4,   // {buf_full, write_idle}
      RESET_CNT      = 4'd5,
      INVALIDATE     = 4'd6
   } ctrl_task_e;

   // Outcome of a completed cache access
   typedef enum logic [2:0] {
      NONE       = 3'd0,
      READ_HIT   = 3'd1,   // Minus one gives the counter slot
      READ_MISS  = 3'd2,
      WRITE_HIT  = 3'd3,
      WRITE_MISS = 3'd4
   } access_ev_e;

   localparam int CNT_W = 16;   // Event counter width

endpackage

// ==== common/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Address layout
   ////////////////////////////////////////////////////////////////////////////

   localparam int ADDR_W     = 16;   // Byte address, select bit not included
   localparam int DATA_W     = 32;   // One word
   localparam int INDEX_W    = 4;    // 16 lines
   localparam int WORD_OFF_W = 2;    // Four words per line
   localparam int TASK_W     = 4;    // Controller task field

   // Geometry following from the widths above
   localparam int BYTE_OFF_W = $clog2(DATA_W/8);
   localparam int TAG_W      = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;
   localparam int LINE_WORDS = 2**WORD_OFF_W;

   // Address as seen by the cache memory
   typedef struct packed {
      logic [TAG_W-1:0]      tag;
      logic [INDEX_W-1:0]    index;
      logic [WORD_OFF_W-1:0] word_off;
      logic [BYTE_OFF_W-1:0] byte_off;
   } cache_addr_t;

   // Address as seen by the controller
   typedef struct packed {
      logic [ADDR_W-TASK_W-1:0] unused;
      logic [TASK_W-1:0]        task_id;   // Low bits pick the task
   } ctrl_addr_t;

   // Same request word, two readings
   typedef union packed {
      cache_addr_t cache;
      ctrl_addr_t  ctrl;
   } req_addr_u;

endpackage
